// File: Bender.yml
package:
  name: rp_analog

export_include_dirs:
  - design

sources:
  - files:
      - design/rp_pkg.sv
      - design/cts_timer.sv
      - design/dac_sequencer.sv
      - design/dac_formatter.sv
      - design/adc_capture.sv
      - design/pdm_modulator.sv
      - design/rp_analog_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_rp_analog.sv

// File: build.f
+incdir+design
design/rp_pkg.sv
design/cts_timer.sv
design/dac_sequencer.sv
design/dac_formatter.sv
design/adc_capture.sv
design/pdm_modulator.sv
design/rp_analog_top.sv
test/tb_clock_gen.sv
test/tb_rp_analog.sv

// File: design/adc_capture.sv
`include "rp_defines.svh"

module adc_capture (
  input  logic                       adc_clk,
  input  logic                       top_rst,
  input  rp_pkg::raw_t [`RP_CHN-1:0] adc_raw_i,
  input  rp_pkg::mux_cfg_t           cfg_i,
  input  rp_pkg::smp_t [`RP_CHN-1:0] loop_smp_i,
  output rp_pkg::smp_t [`RP_CHN-1:0] adc_smp_o
);

  //////////////////////////////////////////////////////////////////////
  // Per-channel capture
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `RP_CHN; i++) begin : g_chn

    // Converted ADC sample
    rp_pkg::smp_t adc_conv;
    // Registered sample
    rp_pkg::smp_t smp_q;

    // MSB kept, bits 14..2 inverted
    // Two low bits only used by 16-bit parts
    assign adc_conv = {adc_raw_i[i][`RP_ADC_RAW_W-1],
                       ~adc_raw_i[i][`RP_ADC_RAW_W-2:`RP_ADC_RAW_W-`RP_SMP_W]};

    // Input register with digital loopback
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        smp_q <= '0;
      end else if (cfg_i.mux_loop[i]) begin
        // Generator sample after mute
        smp_q <= loop_smp_i[i];
      end else begin
        smp_q <= adc_conv;
      end
    end

    assign adc_smp_o[i] = smp_q;

  end

endmodule

// File: design/cts_timer.sv
`include "rp_defines.svh"

module cts_timer (
  input  logic                adc_clk,
  input  logic                top_rst,
  output logic [`RP_TS_W-1:0] cts_o,
  output logic                hold_done_o
);

  // Last count of the DAC reset hold
  localparam logic [`RP_TS_W-1:0] HOLD_LAST = `RP_DAC_RST_CYCLES - 1;

  //////////////////////////////////////////////////////////////////////
  // Free-running time stamp
  //////////////////////////////////////////////////////////////////////

  // Counts adc_clk cycles since reset release
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      cts_o <= '0;
    end else begin
      cts_o <= cts_o + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // DAC reset hold
  //////////////////////////////////////////////////////////////////////

  // Hold ends on the same counter, no second timer
  // Stays high once reached, wrap takes far too long to matter
  assign hold_done_o = (cts_o >= HOLD_LAST);

endmodule

// File: design/dac_formatter.sv
`include "rp_defines.svh"

module dac_formatter (
  input  logic                             adc_clk,
  input  logic                             top_rst,
  input  rp_pkg::smp_t [`RP_CHN-1:0]       gen_smp_i,
  input  rp_pkg::mux_cfg_t                 cfg_i,
  input  rp_pkg::dac_ctl_t                 ctl_i,
  output rp_pkg::smp_t [`RP_CHN-1:0]       loop_smp_o,
  output rp_pkg::dac_bus_t                 dac_o
);

  // Converted word per channel
  rp_pkg::dac_word_t [`RP_CHN-1:0] dac_word;
  // Next value of the pin register
  rp_pkg::dac_bus_t                dac_d;

  //////////////////////////////////////////////////////////////////////
  // Mute and conversion
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `RP_CHN; i++) begin
      // Muted channel sends mid-scale
      loop_smp_o[i] = cfg_i.mux_mute[i] ? '0 : gen_smp_i[i];
      // Sign kept, magnitude bits inverted
      // Gives offset binary with negative slope
      dac_word[i] = {loop_smp_o[i][`RP_SMP_W-1], ~loop_smp_o[i][`RP_SMP_W-2:0]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    dac_d.rst = ctl_i.rst;
    // Select marks channel 0 on the shared bus
    dac_d.sel = ~ctl_i.rst & ~ctl_i.ch;
    // Bus parked at zero while the DAC is held
    dac_d.dat = ctl_i.rst ? '0 : dac_word[ctl_i.ch];
  end

  // One cycle latency, all three fields move together
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_o.rst <= 1'b1;
      dac_o.sel <= 1'b0;
      dac_o.dat <= '0;
    end else begin
      dac_o <= dac_d;
    end
  end

  // Quiet bus for as long as the DAC sees reset
  a_rst_dat_zero: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    dac_o.rst |-> (dac_o.dat == '0)
  );

endmodule

// File: design/dac_sequencer.sv
module dac_sequencer (
  input  logic              adc_clk,
  input  logic              top_rst,
  input  logic              hold_done_i,
  output rp_pkg::dac_ctl_t  ctl_o
);

  rp_pkg::dac_state_e state;
  rp_pkg::dac_state_e state_nxt;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  // Hold in reset, then interleave one channel per cycle
  always_comb begin
    state_nxt = state;
    unique case (state)
      rp_pkg::DAC_RESET: begin
        // Leave on the edge where the hold is done
        if (hold_done_i) begin
          state_nxt = rp_pkg::DAC_CH0;
        end
      end
      rp_pkg::DAC_CH0: begin
        state_nxt = rp_pkg::DAC_CH1;
      end
      rp_pkg::DAC_CH1: begin
        state_nxt = rp_pkg::DAC_CH0;
      end
      default: begin
        // Unused code, back to safe state
        state_nxt = rp_pkg::DAC_RESET;
      end
    endcase
  end

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      state <= rp_pkg::DAC_RESET;
    end else begin
      state <= state_nxt;
    end
  end

  // Decoded control toward the formatter
  assign ctl_o.rst = (state == rp_pkg::DAC_RESET);
  assign ctl_o.ch  = (state == rp_pkg::DAC_CH1);

  // No way back into reset hold without top_rst
  a_no_reenter: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    (state != rp_pkg::DAC_RESET) |=> (state != rp_pkg::DAC_RESET)
  );

  // Strict alternation, channel 1 always after channel 0
  a_ch0_ch1: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    (state == rp_pkg::DAC_CH0) |=> (state == rp_pkg::DAC_CH1)
  );

endmodule

// File: design/pdm_modulator.sv
`include "rp_defines.svh"

module pdm_modulator (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  input  rp_pkg::pdm_val_t [`RP_PDM_CHN-1:0] val_i,
  output logic [`RP_PDM_CHN-1:0]             pdm_o
);

  // Range with one guard bit, matches the sum width
  localparam logic [`RP_PDM_W:0] RNG = `RP_PDM_RNG;

  //////////////////////////////////////////////////////////////////////
  // First-order modulators
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `RP_PDM_CHN; i++) begin : g_pdm

    // Residue, always below range
    rp_pkg::pdm_val_t   acc;
    // Sum and sum minus range
    logic [`RP_PDM_W:0] sum;
    logic [`RP_PDM_W:0] dif;
    logic               pdm_q;

    assign sum = {1'b0, acc} + {1'b0, val_i[i]};
    assign dif = sum - RNG;

    // Overflow emits a one and drops the range
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        acc   <= '0;
        pdm_q <= 1'b0;
      end else if (sum >= RNG) begin
        acc   <= dif[`RP_PDM_W-1:0];
        pdm_q <= 1'b1;
      end else begin
        acc   <= sum[`RP_PDM_W-1:0];
        pdm_q <= 1'b0;
      end
    end

    assign pdm_o[i] = pdm_q;

    // Residue bound keeps ones count exact per window
    a_acc_range: assert property (
      @(posedge adc_clk) disable iff (top_rst)
      ({1'b0, acc} < RNG)
    );

  end

endmodule

// File: design/rp_analog_top.sv
`include "rp_defines.svh"

module rp_analog_top (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  // ADC pins and generator samples
  input  rp_pkg::raw_t     [`RP_CHN-1:0]     adc_dat_i,
  input  rp_pkg::smp_t     [`RP_CHN-1:0]     gen_dat_i,
  // Static configuration levels
  input  rp_pkg::mux_cfg_t                   cfg_i,
  input  rp_pkg::pdm_val_t [`RP_PDM_CHN-1:0] pdm_val_i,
  // Captured samples and time stamp
  output rp_pkg::smp_t     [`RP_CHN-1:0]     adc_smp_o,
  output logic             [`RP_TS_W-1:0]    cts_o,
  // DAC pins
  output rp_pkg::dac_word_t                  dac_dat_o,
  output logic                               dac_sel_o,
  output logic                               dac_rst_o,
  // PDM pins
  output logic             [`RP_PDM_CHN-1:0] dac_pwm_o
);

  logic                         hold_done;
  rp_pkg::dac_ctl_t             dac_ctl;
  rp_pkg::dac_bus_t             dac_bus;
  // Muted generator samples for loopback
  rp_pkg::smp_t [`RP_CHN-1:0]   loop_smp;

  //////////////////////////////////////////////////////////////////////
  // Time stamp and DAC sequencing
  //////////////////////////////////////////////////////////////////////

  cts_timer timer (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cts_o       (cts_o),
    .hold_done_o (hold_done)
  );

  dac_sequencer dac_seq (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .hold_done_i (hold_done),
    .ctl_o       (dac_ctl)
  );

  //////////////////////////////////////////////////////////////////////
  // DAC and ADC data path
  //////////////////////////////////////////////////////////////////////

  dac_formatter dac_fmt (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .gen_smp_i  (gen_dat_i),
    .cfg_i      (cfg_i),
    .ctl_i      (dac_ctl),
    .loop_smp_o (loop_smp),
    .dac_o      (dac_bus)
  );

  // Pin bundle onto separate ports
  assign dac_dat_o = dac_bus.dat;
  assign dac_sel_o = dac_bus.sel;
  assign dac_rst_o = dac_bus.rst;

  adc_capture adc_cap (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_raw_i  (adc_dat_i),
    .cfg_i      (cfg_i),
    .loop_smp_i (loop_smp),
    .adc_smp_o  (adc_smp_o)
  );

  // Slow analog outputs
  pdm_modulator pdm_mod (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .val_i   (pdm_val_i),
    .pdm_o   (dac_pwm_o)
  );

endmodule

// File: design/rp_defines.svh
`ifndef RP_DEFINES_SVH
`define RP_DEFINES_SVH

// ADC raw word as delivered by the converter pins
`define RP_ADC_RAW_W 16

// Internal signed sample, also the DAC bus width
`define RP_SMP_W 14

// Analog channels, both ADC and DAC side
`define RP_CHN 2

// Current time stamp width
`define RP_TS_W 64

// DAC held in reset this many cycles after top_rst
`define RP_DAC_RST_CYCLES 16

// Pulse-density outputs
`define RP_PDM_CHN 4
`define RP_PDM_W 8

// Modulator range, full scale duty
`define RP_PDM_RNG 255

`endif

// File: design/rp_pkg.sv
`include "rp_defines.svh"

package rp_pkg;

  // Signed sample, two's complement
  typedef logic signed [`RP_SMP_W-1:0] smp_t;

  // Raw ADC word, lowest 2 bits unused by 14-bit parts
  typedef logic [`RP_ADC_RAW_W-1:0] raw_t;

  // Offset-inverted word on the DAC pins
  typedef logic [`RP_SMP_W-1:0] dac_word_t;

  // PDM duty value
  typedef logic [`RP_PDM_W-1:0] pdm_val_t;

  // Static mux configuration, one bit per channel
  typedef struct packed {
    logic [`RP_CHN-1:0] mux_loop;  // generator sample replaces ADC
    logic [`RP_CHN-1:0] mux_mute;  // generator sample forced to zero
  } mux_cfg_t;

  // DAC sequencer states
  typedef enum logic [1:0] {
    DAC_RESET = 2'd0,
    DAC_CH0   = 2'd1,
    DAC_CH1   = 2'd2
  } dac_state_e;

  // Sequencer to formatter control
  typedef struct packed {
    logic rst;
    logic ch;
  } dac_ctl_t;

  // Registered DAC pin bundle
  typedef struct packed {
    logic      rst;
    logic      sel;
    dac_word_t dat;
  } dac_bus_t;

endpackage

// File: test/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 10
) (
  output logic adc_clk_o,
  output logic top_rst_o
);

  // Free-running ADC clock
  initial begin
    adc_clk_o = 1'b0;
    forever #(PERIOD / 2) adc_clk_o = ~adc_clk_o;
  end

  // Reset held for a fixed number of edges, released mid-cycle
  initial begin
    top_rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge adc_clk_o);
    @(negedge adc_clk_o);
    top_rst_o = 1'b0;
  end

endmodule

// File: test/tb_rp_analog.sv
`include "rp_defines.svh"

module tb_rp_analog;

  localparam int ROWS           = 6;
  localparam int ROW_CYCLES     = 300;
  localparam int TIMEOUT_CYCLES = ROWS * ROW_CYCLES + 200;
  // PDM window, start offset and length
  localparam int WIN_START      = 10;
  localparam int WIN_LEN        = `RP_PDM_RNG;

  // One stimulus row
  typedef struct packed {
    rp_pkg::raw_t     [`RP_CHN-1:0]     adc;
    rp_pkg::smp_t     [`RP_CHN-1:0]     gen;
    rp_pkg::mux_cfg_t                   cfg;
    rp_pkg::pdm_val_t [`RP_PDM_CHN-1:0] pdm;
  } stim_t;

  logic                               adc_clk;
  logic                               top_rst;
  rp_pkg::raw_t     [`RP_CHN-1:0]     adc_dat;
  rp_pkg::smp_t     [`RP_CHN-1:0]     gen_dat;
  rp_pkg::mux_cfg_t                   cfg;
  rp_pkg::pdm_val_t [`RP_PDM_CHN-1:0] pdm_val;
  rp_pkg::smp_t     [`RP_CHN-1:0]     adc_smp;
  logic             [`RP_TS_W-1:0]    cts;
  rp_pkg::dac_word_t                  dac_dat;
  logic                               dac_sel;
  logic                               dac_rst;
  logic             [`RP_PDM_CHN-1:0] dac_pwm;

  stim_t rows [ROWS];
  string names [ROWS];
  string cur_name;
  int    cycle_cnt;

  tb_clock_gen #(.PERIOD(8), .RST_CYCLES(10)) clk_gen (
    .adc_clk_o (adc_clk),
    .top_rst_o (top_rst)
  );

  rp_analog_top dut0 (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat),
    .gen_dat_i (gen_dat),
    .cfg_i     (cfg),
    .pdm_val_i (pdm_val),
    .adc_smp_o (adc_smp),
    .cts_o     (cts),
    .dac_dat_o (dac_dat),
    .dac_sel_o (dac_sel),
    .dac_rst_o (dac_rst),
    .dac_pwm_o (dac_pwm)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference conversions
  //////////////////////////////////////////////////////////////////////

  // Drop two unused LSBs, flip the 13 magnitude bits
  function automatic rp_pkg::smp_t raw_to_smp(input rp_pkg::raw_t raw);
    return rp_pkg::smp_t'(raw >> 2) ^ 14'h1fff;
  endfunction

  // Mute forces a zero sample
  function automatic rp_pkg::smp_t mute_sample(input rp_pkg::smp_t gen, input logic mute);
    return mute ? 14'h0000 : gen;
  endfunction

  // Offset-inverted DAC word, sign bit untouched
  function automatic rp_pkg::dac_word_t smp_to_dac(input rp_pkg::smp_t s);
    return rp_pkg::dac_word_t'(s) ^ 14'h1fff;
  endfunction

  // Single compare point for every check
  task automatic compare_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("mismatch test=%s signal=%s expected=%0h actual=%0h",
               cur_name, what, expected, actual);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  // Channel 1 first in every concatenation
  task automatic fill_table();
    names[0] = "adc_full_pos_zero";
    rows[0]  = '{adc: {16'h7ffc, 16'h0000}, gen: {14'h0100, 14'h0000},
                 cfg: '{mux_loop: 2'b00, mux_mute: 2'b00},
                 pdm: {8'd1, 8'd128, 8'd255, 8'd0}};
    names[1] = "adc_negative";
    rows[1]  = '{adc: {16'hfffc, 16'h8000}, gen: {14'h2000, 14'h3fff},
                 cfg: '{mux_loop: 2'b00, mux_mute: 2'b00},
                 pdm: {8'd254, 8'd17, 8'd192, 8'd64}};
    names[2] = "gen_mute_ch0";
    rows[2]  = '{adc: {16'hc3a8, 16'h1234}, gen: {14'h0abc, 14'h1234},
                 cfg: '{mux_loop: 2'b00, mux_mute: 2'b01},
                 pdm: {8'd200, 8'd100, 8'd0, 8'd255}};
    names[3] = "loop_ch1";
    rows[3]  = '{adc: {16'h9001, 16'h4000}, gen: {14'h15a5, 14'h2a5a},
                 cfg: '{mux_loop: 2'b10, mux_mute: 2'b00},
                 pdm: {8'd128, 8'd77, 8'd250, 8'd3}};
    names[4] = "loop_ch0_muted";
    rows[4]  = '{adc: {16'h0004, 16'hbeef}, gen: {14'h3001, 14'h0fff},
                 cfg: '{mux_loop: 2'b01, mux_mute: 2'b01},
                 pdm: {8'd127, 8'd254, 8'd2, 8'd1}};
    names[5] = "mute_both_full_neg";
    rows[5]  = '{adc: {16'h7fff, 16'hffff}, gen: {14'h2000, 14'h1fff},
                 cfg: '{mux_loop: 2'b00, mux_mute: 2'b11},
                 pdm: {8'd255, 8'd255, 8'd0, 8'd0}};
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [63:0]       exp_cts;
    logic              exp_rst;
    logic              exp_sel;
    rp_pkg::smp_t      exp_smp [`RP_CHN];
    rp_pkg::dac_word_t exp_dac [`RP_CHN];
    int                ones [`RP_PDM_CHN];

    adc_dat  = '0;
    gen_dat  = '0;
    cfg      = '0;
    pdm_val  = '0;
    cur_name = "reset";
    exp_cts  = '0;
    fill_table();

    // Outputs parked while top_rst is high
    @(posedge adc_clk);
    #1;
    compare_value("cts_o", 64'd0, cts);
    compare_value("dac_rst_o", 64'd1, dac_rst);
    compare_value("dac_sel_o", 64'd0, dac_sel);
    compare_value("dac_dat_o", 64'd0, dac_dat);
    compare_value("adc_smp_o", 64'd0, adc_smp);
    compare_value("dac_pwm_o", 64'd0, dac_pwm);
    wait (top_rst == 1'b0);

    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < ROW_CYCLES; c++) begin
        @(posedge adc_clk);
        #1;
        // Time stamp, one step per edge since release
        exp_cts = exp_cts + 1;
        compare_value("cts_o", exp_cts, cts);

        // Reset hold and channel interleave derived from the stamp
        exp_rst = (exp_cts <= `RP_DAC_RST_CYCLES);
        exp_sel = (exp_cts >= `RP_DAC_RST_CYCLES + 1) &&
                  ((exp_cts - (`RP_DAC_RST_CYCLES + 1)) % 2 == 0);
        compare_value("dac_rst_o", exp_rst, dac_rst);
        compare_value("dac_sel_o", exp_sel, dac_sel);
        if (exp_rst) begin
          compare_value("dac_dat_o", 64'd0, dac_dat);
        end else if (c >= 2) begin
          compare_value("dac_dat_o", exp_sel ? exp_dac[0] : exp_dac[1], dac_dat);
        end

        // Captured samples, one cycle after the row change
        if (c >= 1) begin
          compare_value("adc_smp_o[0]", exp_smp[0], adc_smp[0]);
          compare_value("adc_smp_o[1]", exp_smp[1], adc_smp[1]);
        end

        // Ones count over a full PDM range window
        if (c >= WIN_START && c < WIN_START + WIN_LEN) begin
          for (int p = 0; p < `RP_PDM_CHN; p++) begin
            ones[p] += dac_pwm[p];
          end
        end
        if (c == WIN_START + WIN_LEN) begin
          for (int p = 0; p < `RP_PDM_CHN; p++) begin
            compare_value($sformatf("dac_pwm_o[%0d] ones", p), pdm_val[p], ones[p]);
          end
        end

        // New row driven after sampling
        if (c == 0) begin
          cur_name = names[r];
          adc_dat  = rows[r].adc;
          gen_dat  = rows[r].gen;
          cfg      = rows[r].cfg;
          pdm_val  = rows[r].pdm;
          for (int i = 0; i < `RP_CHN; i++) begin
            exp_dac[i] = smp_to_dac(mute_sample(rows[r].gen[i], rows[r].cfg.mux_mute[i]));
            exp_smp[i] = rows[r].cfg.mux_loop[i] ?
                         mute_sample(rows[r].gen[i], rows[r].cfg.mux_mute[i]) :
                         raw_to_smp(rows[r].adc[i]);
          end
          for (int p = 0; p < `RP_PDM_CHN; p++) begin
            ones[p] = 0;
          end
        end
      end
    end

    $display("TEST PASS");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    cycle_cnt = 0;
  end

  // Limit covers all rows plus reset margin
  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $fatal(1);
    end
  end

endmodule
